//--- ecc.f
+incdir+.
ecc_field_pkg.sv
ecc_point_pkg.sv
field_alu.sv
point_microcode.sv
point_sequencer.sv
scalar_ladder.sv
ecc_top.sv
ecc_tb.sv

//--- ecc_defines.svh
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// field element width in bits
`define ECC_FIELD_W 16

// largest 16-bit prime
`define ECC_PRIME 65521

// curve y^2 = x^3 + a*x + b, only a enters the formulas
`define ECC_CURVE_A 3

`define ECC_SCALAR_W 8

`endif

//--- ecc_field_pkg.sv
`include "ecc_defines.svh"

package ecc_field_pkg;

    typedef logic [`ECC_FIELD_W-1:0] field_elem_t;

    typedef enum logic [1:0]
    {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_MUL = 2'b10,
        OP_DIV = 2'b11   // a / b
    } field_op_e;

    typedef struct packed
    {
        field_op_e   op;
        field_elem_t a;
        field_elem_t b;
    } field_req_t;

endpackage

//--- ecc_point_pkg.sv
package ecc_point_pkg;

    import ecc_field_pkg::*;

    typedef struct packed
    {
        field_elem_t x;
        field_elem_t y;
    } point_t;

    typedef enum logic [1:0]
    {
        CMD_LOAD   = 2'd0,
        CMD_DOUBLE = 2'd1,
        CMD_ADD    = 2'd2
    } point_cmd_e;

    typedef enum logic [2:0]
    {
        SEL_QX = 3'd0,
        SEL_QY = 3'd1,
        SEL_PX = 3'd2,
        SEL_PY = 3'd3,
        SEL_T1 = 3'd4,
        SEL_T2 = 3'd5,
        SEL_T3 = 3'd6,
        SEL_A  = 3'd7   // curve constant
    } operand_sel_e;

    typedef enum logic [1:0]
    {
        DST_T1     = 2'd0,
        DST_T2     = 2'd1,
        DST_T3     = 2'd2,
        DST_COMMIT = 2'd3   // qy <= result, qx <= t3
    } dest_sel_e;

    typedef struct packed
    {
        field_op_e    op;
        operand_sel_e src_a;
        operand_sel_e src_b;
        dest_sel_e    dst;
        logic         last;
    } micro_op_t;

endpackage

//--- ecc_tb.sv
`timescale 1ns/100ps
`include "ecc_defines.svh"

module ecc_tb
    import ecc_field_pkg::*;
    import ecc_point_pkg::*;
();

    localparam int KW = `ECC_SCALAR_W;
    localparam int NUM_TESTS = 13;
    localparam int ACK_LIMIT = 40000;   // k = 255 needs about 9000 cycles
    localparam longint PRIME_L = `ECC_PRIME;
    localparam longint CURVE_A_L = `ECC_CURVE_A;

    typedef logic [KW-1:0] scalar_t;

    typedef struct packed
    {
        scalar_t    scalar;
        point_t     point;
        point_t     expected;
        logic [3:0] hold;   // extra cycles with i_req high after o_ack
    } test_vec_t;

    logic    i_clk = 1'b0;
    logic    i_reset;
    logic    i_req;
    scalar_t i_scalar;
    point_t  i_point;
    logic    o_ack;
    point_t  o_point;

    test_vec_t   vectors [NUM_TESTS];
    string       vec_name [NUM_TESTS];
    logic [31:0] rng_state = 32'd51171;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          alu_req_count = 0;
    bit          timed_out = 1'b0;

    ecc_top ecc_top_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_req    (i_req),
        .i_scalar (i_scalar),
        .i_point  (i_point),
        .o_ack    (o_ack),
        .o_point  (o_point)
    );

    always #5 i_clk = ~i_clk;

    // arithmetic requests seen by the field unit
    always @(posedge ecc_top_inst.alu_req)
    begin
        alu_req_count = alu_req_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic longint add_mod(input longint a, input longint b);
        return (a + b) % PRIME_L;
    endfunction

    function automatic longint sub_mod(input longint a, input longint b);
        return (a - b + PRIME_L) % PRIME_L;
    endfunction

    function automatic longint mul_mod(input longint a, input longint b);
        return (a * b) % PRIME_L;
    endfunction

    // lsb-first exponentiation where 0 stays 0
    function automatic longint pow_mod(input longint b, input longint e);
        longint r;
        longint base;
        longint n;
        r = 1;
        base = b;
        n = e;
        while (n > 0)
        begin
            if (n % 2 == 1)
            begin
                r = mul_mod(r, base);
            end
            base = mul_mod(base, base);
            n = n / 2;
        end
        return r;
    endfunction

    function automatic longint div_mod(input longint a, input longint b);
        return mul_mod(a, pow_mod(b, PRIME_L - 2));
    endfunction

    function automatic point_t double_point(input point_t q);
        longint x;
        longint y;
        longint lam;
        longint x3;
        point_t r;
        x = longint'(q.x);
        y = longint'(q.y);
        lam = div_mod(add_mod(mul_mod(3, mul_mod(x, x)), CURVE_A_L), mul_mod(2, y));
        x3 = sub_mod(mul_mod(lam, lam), mul_mod(2, x));
        r.x = field_elem_t'(x3);
        r.y = field_elem_t'(sub_mod(mul_mod(lam, sub_mod(x, x3)), y));
        return r;
    endfunction

    function automatic point_t add_points(input point_t q, input point_t p);
        longint lam;
        longint x3;
        point_t r;
        lam = div_mod(sub_mod(longint'(p.y), longint'(q.y)),
                      sub_mod(longint'(p.x), longint'(q.x)));
        x3 = sub_mod(sub_mod(mul_mod(lam, lam), longint'(q.x)), longint'(p.x));
        r.x = field_elem_t'(x3);
        r.y = field_elem_t'(sub_mod(mul_mod(lam, sub_mod(longint'(q.x), x3)), longint'(q.y)));
        return r;
    endfunction

    // msb-first double-and-add from the top set bit
    function automatic point_t scalar_multiply(input scalar_t k, input point_t p);
        point_t q;
        int top;
        int i;
        top = 0;
        for (i = 0; i < KW; i++)
        begin
            if (k[i])
            begin
                top = i;
            end
        end
        q = p;
        for (i = top - 1; i >= 0; i--)
        begin
            q = double_point(q);
            if (k[i])
            begin
                q = add_points(q, p);
            end
        end
        return q;
    endfunction

    task automatic set_vector(input int idx, input string name, input scalar_t k,
                              input longint x, input longint y, input int hold);
        point_t p;
        p.x = field_elem_t'(x);
        p.y = field_elem_t'(y);
        vec_name[idx] = name;
        vectors[idx].scalar = k;
        vectors[idx].point = p;
        vectors[idx].expected = scalar_multiply(k, p);
        vectors[idx].hold = 4'(hold);
    endtask

    task automatic fill_vectors();
        logic [31:0] r;
        longint x;
        longint y;
        int i;
        set_vector(0, "scalar_1", 1, 1234, 5678, 0);
        set_vector(1, "scalar_2", 2, 17, 4242, 0);
        set_vector(2, "scalar_128", 128, 300, 999, 0);
        set_vector(3, "scalar_255", 255, 65000, 40000, 0);
        set_vector(4, "y_zero", 2, 12345, 0, 0);
        // lambda is 0 so x = -2x and y = 0
        vectors[4].expected.x = field_elem_t'(sub_mod(0, mul_mod(2, 12345)));
        vectors[4].expected.y = '0;
        set_vector(5, "held_req", 5, 65520, 65519, 6);
        set_vector(6, "after_hold", 13, 2, 3, 0);
        for (i = 7; i < NUM_TESTS; i++)
        begin
            next_random(r);
            x = longint'(r % 32'd65521);
            next_random(r);
            y = longint'(r % 32'd65521);
            next_random(r);
            set_vector(i, $sformatf("random_%0d", i - 7), scalar_t'(1 + r % 255), x, y, 0);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_ack(input logic level, input int limit, input string name,
                            output int cycles);
        cycles = 0;
        while (o_ack !== level && cycles < limit)
        begin
            @(negedge i_clk);
            cycles++;
        end
        if (o_ack !== level)
        begin
            timed_out = 1'b1;
            $display("TIMEOUT in %s: o_ack did not reach %0b within %0d cycles",
                     name, level, limit);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count != errs_before || timed_out)
        begin
            tests_failed++;
            $display("test %-12s FAILED", name);
        end
        else
        begin
            $display("test %-12s ok", name);
        end
    endtask

    task automatic run_test(input int idx);
        int errs_before;
        int req_base;
        int cycles;
        string name;
        name = vec_name[idx];
        errs_before = error_count;
        req_base = alu_req_count;
        @(negedge i_clk);
        i_scalar = vectors[idx].scalar;
        i_point  = vectors[idx].point;
        i_req    = 1'b1;
        wait_ack(1'b1, ACK_LIMIT, name, cycles);
        if (!timed_out)
        begin
            check_value({name, " o_point"}, vectors[idx].expected, o_point);
            if (vectors[idx].scalar == scalar_t'(1))
            begin
                check_value({name, " alu requests"}, 0, 32'(alu_req_count - req_base));
            end
            repeat (vectors[idx].hold)
            begin
                @(negedge i_clk);
                check_value({name, " held o_ack"}, 32'(1), 32'(o_ack));
                check_value({name, " held o_point"}, vectors[idx].expected, o_point);
            end
            i_req = 1'b0;
            wait_ack(1'b0, 8, name, cycles);
            if (!timed_out)
            begin
                check_value({name, " ack release cycles"}, 32'(1), 32'(cycles));
            end
        end
        report_test(name, errs_before);
    endtask

    initial
    begin
        int idx;
        int errs_before;
        i_reset  = 1'b1;
        i_req    = 1'b0;
        i_scalar = '0;
        i_point  = '0;
        fill_vectors();
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        errs_before = error_count;
        repeat (3)
        begin
            @(negedge i_clk);
            check_value("reset_idle o_ack", 0, 32'(o_ack));
        end
        report_test("reset_idle", errs_before);

        for (idx = 0; idx < NUM_TESTS && !timed_out; idx++)
        begin
            run_test(idx);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (timed_out || error_count != 0)
        begin
            $display("Errors found");
        end
        else
        begin
            $display("No errors");
        end
        $finish;
    end

endmodule

//--- ecc_top.sv
`timescale 1ns/100ps
`include "ecc_defines.svh"

module ecc_top
    import ecc_field_pkg::*;
    import ecc_point_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_req,
    input  logic [`ECC_SCALAR_W-1:0] i_scalar,
    input  point_t                   i_point,
    output logic                     o_ack,
    output point_t                   o_point
);

    logic        cmd_req;
    logic        cmd_ack;
    point_cmd_e  cmd;
    logic [3:0]  step;
    micro_op_t   uop;
    logic        alu_req;
    logic        alu_ack;
    field_req_t  alu_op;
    field_elem_t alu_result;

    scalar_ladder scalar_ladder_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_req     (i_req),
        .i_scalar  (i_scalar),
        .o_ack     (o_ack),
        .o_cmd_req (cmd_req),
        .o_cmd     (cmd),
        .i_cmd_ack (cmd_ack)
    );

    point_sequencer point_sequencer_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_point      (i_point),
        .i_cmd_req    (cmd_req),
        .i_cmd        (cmd),
        .o_cmd_ack    (cmd_ack),
        .o_step       (step),
        .i_uop        (uop),
        .o_alu_req    (alu_req),
        .o_alu        (alu_op),
        .i_alu_ack    (alu_ack),
        .i_alu_result (alu_result),
        .o_point      (o_point)
    );

    point_microcode point_microcode_inst (
        .i_cmd  (cmd),
        .i_step (step),
        .o_uop  (uop)
    );

    field_alu field_alu_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_req    (alu_req),
        .i_op     (alu_op),
        .o_ack    (alu_ack),
        .o_result (alu_result)
    );

endmodule

//--- field_alu.sv
`timescale 1ns/100ps
`include "ecc_defines.svh"

module field_alu
    import ecc_field_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_req,
    input  field_req_t  i_op,
    output logic        o_ack,
    output field_elem_t o_result
);

    localparam int W = `ECC_FIELD_W;
    localparam int CNT_W = $clog2(W);
    localparam logic [W:0] PRIME = (W+1)'(`ECC_PRIME);
    localparam logic [W-1:0] EXP = W'(`ECC_PRIME - 2);   // fermat exponent

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_NEXT, ST_ACK} alu_state_e;
    typedef enum logic [1:0] {JOB_LAST, JOB_SQR, JOB_MULB} alu_job_e;

    alu_state_e  state;
    alu_job_e    job;
    alu_job_e    nxt_job;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] exp_idx;
    field_elem_t mul_acc;
    field_elem_t mul_x;
    field_elem_t mul_y;
    field_elem_t nxt_y;
    field_elem_t dbl_acc;
    field_elem_t step_acc;

    function automatic field_elem_t mod_add(input field_elem_t a, input field_elem_t b);
        logic [W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= PRIME)
        begin
            s = s - PRIME;
        end
        return s[W-1:0];
    endfunction

    function automatic field_elem_t mod_sub(input field_elem_t a, input field_elem_t b);
        logic [W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b)
        begin
            d = d + PRIME;   // wraps back into range
        end
        return d[W-1:0];
    endfunction

    // one msb-first multiplier bit per cycle
    assign dbl_acc  = mod_add(mul_acc, mul_acc);
    assign step_acc = mul_y[bit_cnt] ? mod_add(dbl_acc, mul_x) : dbl_acc;

    // square-and-multiply walk for division
    always_comb
    begin
        nxt_job = JOB_SQR;
        nxt_y   = mul_acc;
        if (job == JOB_SQR && EXP[exp_idx])
        begin
            nxt_job = JOB_MULB;
            nxt_y   = i_op.b;
        end
        else if (exp_idx == '0)
        begin
            nxt_job = JOB_LAST;   // times numerator
            nxt_y   = i_op.a;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state   <= ST_IDLE;
            job     <= JOB_LAST;
            bit_cnt <= '0;
            exp_idx <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    bit_cnt <= CNT_W'(W - 1);
                    exp_idx <= CNT_W'(W - 1);
                    if (i_req)
                    begin
                        job   <= (i_op.op == OP_DIV) ? JOB_SQR : JOB_LAST;
                        state <= (i_op.op == OP_ADD || i_op.op == OP_SUB) ? ST_ACK : ST_RUN;
                    end
                end
                ST_RUN:
                begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0)
                    begin
                        state <= ST_NEXT;
                    end
                end
                ST_NEXT:
                begin
                    bit_cnt <= CNT_W'(W - 1);
                    if (job == JOB_LAST)
                    begin
                        state <= ST_ACK;
                    end
                    else
                    begin
                        job   <= nxt_job;
                        state <= ST_RUN;
                        if (nxt_job == JOB_SQR)
                        begin
                            exp_idx <= exp_idx - 1'b1;
                        end
                    end
                end
                default:
                begin
                    if (!i_req)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        case (state)
            ST_IDLE:
            begin
                mul_acc <= '0;
                mul_x   <= (i_op.op == OP_DIV) ? field_elem_t'(1) : i_op.a;   // r = 1
                mul_y   <= (i_op.op == OP_DIV) ? field_elem_t'(1) : i_op.b;
                o_result <= (i_op.op == OP_SUB) ? mod_sub(i_op.a, i_op.b)
                                                : mod_add(i_op.a, i_op.b);
            end
            ST_RUN:
            begin
                mul_acc <= step_acc;
            end
            ST_NEXT:
            begin
                mul_acc <= '0;
                mul_x   <= mul_acc;
                mul_y   <= nxt_y;
                if (job == JOB_LAST)
                begin
                    o_result <= mul_acc;
                end
            end
            default:
            begin
                mul_acc <= mul_acc;
            end
        endcase
    end

    assign o_ack = (state == ST_ACK);

    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_ack) |-> i_req);

endmodule

//--- point_microcode.sv
`timescale 1ns/100ps

module point_microcode
    import ecc_field_pkg::*;
    import ecc_point_pkg::*;
(
    input  point_cmd_e i_cmd,
    input  logic [3:0] i_step,
    output micro_op_t  o_uop
);

    logic [3:0]   tail_step;
    operand_sel_e xo_sel;

    function automatic micro_op_t mk_uop(input field_op_e op, input operand_sel_e a,
                                         input operand_sel_e b, input dest_sel_e d,
                                         input logic last);
        return '{op: op, src_a: a, src_b: b, dst: d, last: last};
    endfunction

    always_comb
    begin
        xo_sel    = (i_cmd == CMD_DOUBLE) ? SEL_QX : SEL_PX;
        tail_step = (i_cmd == CMD_DOUBLE) ? i_step - 4'd6 : i_step - 4'd3;
        o_uop     = mk_uop(OP_SUB, SEL_T2, SEL_QY, DST_COMMIT, 1'b1);

        if (i_cmd == CMD_DOUBLE && i_step < 4'd6)
        begin
            case (i_step)
                4'd0:    o_uop = mk_uop(OP_MUL, SEL_QX, SEL_QX, DST_T1, 1'b0);
                4'd1:    o_uop = mk_uop(OP_ADD, SEL_T1, SEL_T1, DST_T2, 1'b0);
                4'd2:    o_uop = mk_uop(OP_ADD, SEL_T2, SEL_T1, DST_T1, 1'b0);   // 3x^2
                4'd3:    o_uop = mk_uop(OP_ADD, SEL_T1, SEL_A,  DST_T1, 1'b0);
                4'd4:    o_uop = mk_uop(OP_ADD, SEL_QY, SEL_QY, DST_T2, 1'b0);
                default: o_uop = mk_uop(OP_DIV, SEL_T1, SEL_T2, DST_T1, 1'b0);   // lambda
            endcase
        end
        else if (i_cmd == CMD_ADD && i_step < 4'd3)
        begin
            case (i_step)
                4'd0:    o_uop = mk_uop(OP_SUB, SEL_PY, SEL_QY, DST_T1, 1'b0);
                4'd1:    o_uop = mk_uop(OP_SUB, SEL_PX, SEL_QX, DST_T2, 1'b0);
                default: o_uop = mk_uop(OP_DIV, SEL_T1, SEL_T2, DST_T1, 1'b0);
            endcase
        end
        else
        begin
            // shared tail, lambda sits in t1
            case (tail_step)
                4'd0:    o_uop = mk_uop(OP_MUL, SEL_T1, SEL_T1, DST_T2, 1'b0);
                4'd1:    o_uop = mk_uop(OP_SUB, SEL_T2, SEL_QX, DST_T2, 1'b0);
                4'd2:    o_uop = mk_uop(OP_SUB, SEL_T2, xo_sel, DST_T3, 1'b0);   // new x
                4'd3:    o_uop = mk_uop(OP_SUB, SEL_QX, SEL_T3, DST_T2, 1'b0);
                4'd4:    o_uop = mk_uop(OP_MUL, SEL_T1, SEL_T2, DST_T2, 1'b0);
                default: o_uop = mk_uop(OP_SUB, SEL_T2, SEL_QY, DST_COMMIT, 1'b1);
            endcase
        end
    end

endmodule

//--- point_sequencer.sv
`timescale 1ns/100ps
`include "ecc_defines.svh"

module point_sequencer
    import ecc_field_pkg::*;
    import ecc_point_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  point_t      i_point,
    input  logic        i_cmd_req,
    input  point_cmd_e  i_cmd,
    output logic        o_cmd_ack,
    output logic [3:0]  o_step,
    input  micro_op_t   i_uop,
    output logic        o_alu_req,
    output field_req_t  o_alu,
    input  logic        i_alu_ack,
    input  field_elem_t i_alu_result,
    output point_t      o_point
);

    localparam field_elem_t CURVE_A = field_elem_t'(`ECC_CURVE_A);

    typedef enum logic [1:0] {SQ_IDLE, SQ_REQ, SQ_DROP, SQ_ACK} seq_state_e;

    seq_state_e  state;
    point_t      q_reg;   // accumulator
    point_t      p_reg;   // base point
    field_elem_t t1;
    field_elem_t t2;
    field_elem_t t3;

    function automatic field_elem_t pick(input operand_sel_e sel);
        case (sel)
            SEL_QX:  return q_reg.x;
            SEL_QY:  return q_reg.y;
            SEL_PX:  return p_reg.x;
            SEL_PY:  return p_reg.y;
            SEL_T1:  return t1;
            SEL_T2:  return t2;
            SEL_T3:  return t3;
            default: return CURVE_A;
        endcase
    endfunction

    assign o_alu     = '{op: i_uop.op, a: pick(i_uop.src_a), b: pick(i_uop.src_b)};
    assign o_alu_req = (state == SQ_REQ);
    assign o_cmd_ack = (state == SQ_ACK);
    assign o_point   = q_reg;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= SQ_IDLE;
            o_step <= '0;
        end
        else
        begin
            case (state)
                SQ_IDLE:
                begin
                    o_step <= '0;
                    if (i_cmd_req)
                    begin
                        state <= (i_cmd == CMD_LOAD) ? SQ_ACK : SQ_REQ;
                    end
                end
                SQ_REQ:
                begin
                    if (i_alu_ack)
                    begin
                        state <= SQ_DROP;
                    end
                end
                SQ_DROP:
                begin
                    if (!i_alu_ack)
                    begin
                        state  <= i_uop.last ? SQ_ACK : SQ_REQ;
                        o_step <= o_step + 1'b1;
                    end
                end
                default:
                begin
                    if (!i_cmd_req)
                    begin
                        state <= SQ_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == SQ_IDLE && i_cmd_req && i_cmd == CMD_LOAD)
        begin
            p_reg <= i_point;
            q_reg <= i_point;
        end
        if (state == SQ_REQ && i_alu_ack)
        begin
            case (i_uop.dst)
                DST_T1: t1 <= i_alu_result;
                DST_T2: t2 <= i_alu_result;
                DST_T3: t3 <= i_alu_result;
                default:
                begin
                    q_reg.x <= t3;
                    q_reg.y <= i_alu_result;
                end
            endcase
        end
    end

    a_alu_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_alu_req && $past(o_alu_req) |-> $stable(o_alu));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ecc testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f ecc.f --top-module ecc_tb -o ecc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ecc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$log"; then
    exit 1
fi
exit 0

//--- scalar_ladder.sv
`timescale 1ns/100ps
`include "ecc_defines.svh"

module scalar_ladder
    import ecc_point_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_req,
    input  logic [`ECC_SCALAR_W-1:0] i_scalar,
    output logic                     o_ack,
    output logic                     o_cmd_req,
    output point_cmd_e               o_cmd,
    input  logic                     i_cmd_ack
);

    localparam int KW = `ECC_SCALAR_W;
    localparam int CW = $clog2(KW);

    typedef enum logic [2:0] {LD_IDLE, LD_CMD, LD_WAIT, LD_SKIP, LD_NEXT, LD_DONE} ladder_e;

    ladder_e       state;
    logic [KW-1:0] key;
    logic [CW-1:0] bit_idx;   // key-bit counter

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state   <= LD_IDLE;
            o_cmd   <= CMD_LOAD;
            bit_idx <= '0;
        end
        else
        begin
            case (state)
                LD_IDLE:
                begin
                    if (i_req)
                    begin
                        bit_idx <= CW'(KW - 1);
                        o_cmd   <= CMD_LOAD;
                        state   <= LD_CMD;
                    end
                end
                LD_CMD:
                begin
                    if (i_cmd_ack)
                    begin
                        state <= LD_WAIT;
                    end
                end
                LD_WAIT:
                begin
                    if (!i_cmd_ack)
                    begin
                        if (o_cmd == CMD_LOAD)
                        begin
                            state <= LD_SKIP;
                        end
                        else if (o_cmd == CMD_DOUBLE && key[bit_idx])
                        begin
                            o_cmd <= CMD_ADD;
                            state <= LD_CMD;
                        end
                        else
                        begin
                            state <= LD_NEXT;
                        end
                    end
                end
                LD_SKIP:
                begin
                    // leading zeros cost one cycle each
                    if (key[bit_idx] || bit_idx == '0)
                    begin
                        state <= LD_NEXT;
                    end
                    else
                    begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                LD_NEXT:
                begin
                    if (bit_idx == '0)
                    begin
                        state <= LD_DONE;
                    end
                    else
                    begin
                        bit_idx <= bit_idx - 1'b1;
                        o_cmd   <= CMD_DOUBLE;
                        state   <= LD_CMD;
                    end
                end
                default:
                begin
                    if (!i_req)
                    begin
                        state <= LD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == LD_IDLE && i_req)
        begin
            key <= i_scalar;
        end
    end

    assign o_cmd_req = (state == LD_CMD);
    assign o_ack     = (state == LD_DONE);

    a_req_after_ack_low: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_cmd_req) |-> !i_cmd_ack);

endmodule
